/* sim.f */
logic/debugPkg.sv
logic/asyncFifo.sv
logic/debugSerial.sv
logic/debugBridge.sv
logic/ledCommandEngine.sv
logic/debugTop.sv
tb/debugChecker.sv
tb/debugTopTb.sv

/* Makefile */
VERILATOR  = verilator
TOP        = debugTopTb
FILELIST   = sim.f
COMMON     = --timing --timescale 1ns/100ps --top-module $(TOP) -f $(FILELIST)
LINT_FLAGS = --lint-only
SIM_FLAGS  = --binary -Wno-fatal --Mdir obj_dir -o simv
LOG        = sim.log
PASS_TEXT  = Simulation finished: PASS

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) $(COMMON)

sim:
	$(VERILATOR) $(SIM_FLAGS) $(COMMON)
	./obj_dir/simv | tee $(LOG)
	grep -q "$(PASS_TEXT)" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

/* tb/debugVectors.txt */
// Columns: mode cmd len byte0 byte1 led, two hex digits each
// Mode 01 sends the command back to back with the next one, no gap
008101810001
008001800000
008202000200
00A501A50005
00C501C50005
008202050505
00AF01AF000F
00800180000E
// Burst of six commands
01A301A30003
018101810003
018202030A03
01FF01FF0003
01A901A90009
018202090D09
// Back to single commands
00A001A00000
008202000F00

/* tb/debugTopTb.sv */
`timescale 1ns/100ps

module debugTopTb;
    import debugPkg::*;

    localparam int MaxVectors = 64;

    logic                clk;
    logic                reset;
    logic                debugClk;
    logic                debugCs;
    logic                debugDi;
    logic                debugDo;
    logic [LedCount-1:0] led;

    // mode, cmd, len, byte0, byte1, led
    logic [47:0] vectors [MaxVectors];
    int          numVectors = 0;
    int          cycleLimit = 0;
    int          cycles = 0;
    logic [31:0] lfsr = 32'hca6d;

    debugTop debugTop_inst (
        .clk(clk), .reset(reset), .debugClk(debugClk), .debugCs(debugCs),
        .debugDi(debugDi), .debugDo(debugDo), .led(led)
    );

    debugChecker frameCheck (
        .debugClk(debugClk), .debugCs(debugCs), .debugDo(debugDo), .led(led)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // Host clock, three times slower than clk
    initial begin
        debugClk = 1'b0;
        forever #12 debugClk = ~debugClk;
    end

    // Galois form of x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        return state[0] ? ((state >> 1) ^ 32'h8020_0003) : (state >> 1);
    endfunction

    task automatic takeBits(input int count, output int value);
        value = 0;
        for (int i = 0; i < count; i++) begin
            value = (value << 1) | int'(lfsr[0]);
            lfsr  = lfsrStep(lfsr);
        end
    endtask

    // One host bit, applied just after the debugClk edge
    task automatic driveBit(input logic cs, input logic bitValue);
        @(posedge debugClk);
        #1;
        debugCs = cs;
        debugDi = bitValue;
    endtask

    task automatic sendByte(input logic [ByteWidth-1:0] value);
        for (int i = ByteWidth - 1; i >= 0; i--) begin
            driveBit(1'b1, value[i]);
        end
    endtask

    // Keep clocking zeros so the response can shift out
    task automatic waitFrames(input int target);
        while (frameCheck.doneCount < target) begin
            driveBit(1'b1, 1'b0);
        end
    endtask

    // ==================================================
    // Main sequence
    // ==================================================
    initial begin
        int          gap;
        int          zeros;
        logic [47:0] entry;
        logic        burst;
        logic        lastOfGroup;

        reset   = 1'b1;
        debugCs = 1'b0;
        debugDi = 1'b0;
        foreach (vectors[i]) begin
            vectors[i] = '0;
        end
        $readmemh("tb/debugVectors.txt", vectors);
        while (numVectors < MaxVectors && vectors[numVectors][39:32] != CmdNop) begin
            numVectors++;
        end
        cycleLimit = numVectors * 600 + 200;

        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;
        // Give the debugClk side time to leave reset
        repeat (6) driveBit(1'b0, 1'b0);

        for (int i = 0; i < numVectors; i++) begin
            entry = vectors[i];
            burst = (entry[47:40] != 8'h00);
            if (!burst) begin
                takeBits(4, gap);
                repeat (gap) driveBit(1'b0, 1'b0);
                // Leading zeros must be skipped by the framer
                takeBits(3, zeros);
                repeat (zeros) driveBit(1'b1, 1'b0);
            end
            sendByte(entry[39:32]);
            lastOfGroup = !burst || (i == numVectors - 1) || (vectors[i + 1][47:40] == 8'h00);
            frameCheck.queueExpected(entry, lastOfGroup);
            if (lastOfGroup) begin
                waitFrames(i + 1);
            end
        end

        repeat (4) @(posedge clk);
        $display("Tests passed: %0d, failed: %0d", frameCheck.passCount, frameCheck.failCount);
        if (numVectors > 0 && frameCheck.failCount == 0 && frameCheck.passCount == numVectors) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

    // Run limit scales with the number of vectors
    always @(posedge clk) begin
        cycles++;
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            $display("Timeout after %0d clk cycles, tests %0d to %0d got no response",
                     cycles, frameCheck.doneCount, numVectors - 1);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

endmodule

/* tb/debugChecker.sv */
`timescale 1ns/100ps

module debugChecker (
    input logic                          debugClk,
    input logic                          debugCs,
    input logic                          debugDo,
    input logic [debugPkg::LedCount-1:0] led
);
    import debugPkg::*;

    int passCount = 0;
    int failCount = 0;
    int doneCount = 0;

    // Top bit marks a frame whose LED value can be checked
    logic [48:0] expected[$];

    logic [ByteWidth-1:0] shiftByte = '0;
    int                   bitCount = 0;
    int                   frameLen = 0;
    logic [ByteWidth-1:0] frameBytes[$];

    task automatic queueExpected(input logic [47:0] entry, input logic checkLed);
        expected.push_back({checkLed, entry});
    endtask

    task automatic compareFrame();
        logic [48:0]          e;
        logic [ByteWidth-1:0] got1;
        logic                 match;
        if (expected.size() == 0) begin
            $display("Frame of %0d bytes at %0t arrived with no command outstanding",
                     frameLen, $time);
            failCount++;
            return;
        end
        e     = expected.pop_front();
        got1  = (frameBytes.size() > 1) ? frameBytes[1] : '0;
        match = (frameLen == int'(e[31:24])) && (frameBytes[0] == e[23:16]);
        if (e[31:24] == 8'd2) begin
            match = match && (got1 == e[15:8]);
        end
        // Inside a burst later commands may already have moved the LEDs
        if (e[48]) begin
            match = match && (ByteWidth'(led) == e[7:0]);
        end
        if (match) begin
            passCount++;
            $display("test %0d cmd %h: len %0d, led %h ok", doneCount, e[39:32], frameLen, led);
        end else begin
            failCount++;
            $display("FAIL at %0t: test %0d cmd %h expected len %0d bytes %h %h led %h,",
                     $time, doneCount, e[39:32], e[31:24], e[23:16], e[15:8], e[7:0],
                     " got len %0d bytes %h %h led %h", frameLen, frameBytes[0], got1, led);
        end
        doneCount++;
    endtask

    task automatic takeByte(input logic [ByteWidth-1:0] value);
        if (frameLen == 0) begin
            // Zero bytes fill the line between frames
            if (value != '0) begin
                frameLen = int'(value);
                frameBytes.delete();
            end
        end else begin
            frameBytes.push_back(value);
            if (frameBytes.size() == frameLen) begin
                compareFrame();
                frameLen = 0;
            end
        end
    endtask

    // ==================================================
    // Byte assembly, MSB first, only while selected
    // ==================================================
    always @(posedge debugClk) begin
        if (debugCs) begin
            shiftByte = {shiftByte[ByteWidth-2:0], debugDo};
            bitCount++;
            if (bitCount == ByteWidth) begin
                bitCount = 0;
                takeByte(shiftByte);
            end
        end
    end

endmodule

/* logic/debugTop.sv */
`timescale 1ns/100ps

module debugTop (
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          debugClk,
    input  logic                          debugCs,
    input  logic                          debugDi,
    output logic                          debugDo,
    output logic [debugPkg::LedCount-1:0] led
);
    import debugPkg::*;

    // Command path from the bridge
    logic [ByteWidth-1:0] cmd;
    logic                 cmdReady;
    logic                 cmdTrigger;

    // Response path back to the host
    logic [ByteWidth-1:0] msg;
    logic [ByteWidth-1:0] msgLen;
    logic                 msgTrigger;

    debugBridge bridge (
        .clk(clk),
        .reset(reset),
        .cmd(cmd),
        .cmdReady(cmdReady),
        .cmdTrigger(cmdTrigger),
        .msg(msg),
        .msgLen(msgLen),
        .msgTrigger(msgTrigger),
        .debugClk(debugClk),
        .debugCs(debugCs),
        .debugDi(debugDi),
        .debugDo(debugDo)
    );

    ledCommandEngine engine (
        .clk(clk),
        .reset(reset),
        .cmd(cmd),
        .cmdReady(cmdReady),
        .cmdTrigger(cmdTrigger),
        .msg(msg),
        .msgLen(msgLen),
        .msgTrigger(msgTrigger),
        .led(led)
    );

endmodule

/* logic/ledCommandEngine.sv */
`timescale 1ns/100ps

module ledCommandEngine (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [debugPkg::ByteWidth-1:0] cmd,
    input  logic                           cmdReady,
    output logic                           cmdTrigger,
    output logic [debugPkg::ByteWidth-1:0] msg,
    output logic [debugPkg::ByteWidth-1:0] msgLen,
    input  logic                           msgTrigger,
    output logic [debugPkg::LedCount-1:0]  led
);
    import debugPkg::*;

    logic                 cmdAccept;
    logic                 isLedSet;
    logic [ByteWidth-1:0] count;
    logic [ByteWidth-1:0] msgNext;
    logic [ByteWidth-1:0] ledByte;

    // A stray NOP is ignored and gets no response
    assign cmdAccept = cmdReady && (msgLen == '0) && (cmd != CmdNop);
    assign isLedSet  = (cmd[ByteWidth-1:4] == CmdLedSetMask[ByteWidth-1:4]);
    assign ledByte   = {{(ByteWidth-LedCount){1'b0}}, led};

    always_ff @(posedge clk) begin
        if (reset) begin
            cmdTrigger <= 1'b0;
            msgLen     <= '0;
            led        <= '0;
            count      <= '0;
        end else begin
            cmdTrigger <= 1'b0;
            if (msgLen != '0) begin
                if (msgTrigger) begin
                    msgLen <= msgLen - 1'b1;
                end
            end else if (cmdAccept) begin
                count  <= count + 1'b1;
                msgLen <= (cmd == CmdStatus) ? ByteWidth'(2) : ByteWidth'(1);
                if (isLedSet) begin
                    led <= cmd[LedCount-1:0];
                end else if (cmd == CmdLedOn) begin
                    led[0] <= 1'b1;
                end else if (cmd == CmdLedOff) begin
                    led[0] <= 1'b0;
                end
            end else begin
                // Request every other cycle so a popped byte is seen before the next pop
                cmdTrigger <= !cmdTrigger;
            end
        end
    end

    // Response bytes
    always_ff @(posedge clk) begin
        if (cmdAccept) begin
            if (cmd == CmdStatus) begin
                msg     <= ledByte;
                msgNext <= count;
            end else begin
                msg <= cmd;
            end
        end else if (msgTrigger) begin
            msg <= msgNext;
        end
    end

endmodule

/* logic/debugBridge.sv */
`timescale 1ns/100ps

module debugBridge (
    input  logic                           clk,
    input  logic                           reset,
    output logic [debugPkg::ByteWidth-1:0] cmd,
    output logic                           cmdReady,
    input  logic                           cmdTrigger,
    input  logic [debugPkg::ByteWidth-1:0] msg,
    input  logic [debugPkg::ByteWidth-1:0] msgLen,
    output logic                           msgTrigger,
    input  logic                           debugClk,
    input  logic                           debugCs,
    input  logic                           debugDi,
    output logic                           debugDo
);
    import debugPkg::*;

    logic                 debugResetMeta;
    logic                 debugReset;

    logic                 inWrite;
    logic [ByteWidth-1:0] inWriteData;
    logic                 inWriteOk;
    logic                 inRead;
    logic                 inReadOk;

    logic                 outWrite;
    logic [ByteWidth-1:0] outWriteData;
    logic                 outWriteOk;
    logic                 outRead;
    logic [ByteWidth-1:0] outReadData;
    logic                 outReadOk;

    // Length byte already queued for the current response
    logic                 lenSent;
    logic                 msgActive;

    always_ff @(posedge debugClk) begin
        debugResetMeta <= reset;
        debugReset     <= debugResetMeta;
    end

    // ==================================================
    // Command queue, debugClk to clk
    // ==================================================
    asyncFifo #(.width(ByteWidth), .depth(InFifoDepth)) inFifo (
        .wclk(debugClk), .rclk(clk), .reset(reset),
        .write(inWrite), .writeData(inWriteData), .writeOk(inWriteOk),
        .read(inRead), .readData(cmd), .readOk(inReadOk)
    );

    assign msgActive = (msgLen != '0);
    assign inRead    = cmdTrigger && !msgActive;

    always_ff @(posedge clk) begin
        if (reset) begin
            cmdReady <= 1'b0;
        end else begin
            cmdReady <= inRead && inReadOk;
        end
    end

    // ==================================================
    // Response queue, clk to debugClk
    // ==================================================
    asyncFifo #(.width(ByteWidth), .depth(OutFifoDepth)) outFifo (
        .wclk(clk), .rclk(debugClk), .reset(reset),
        .write(outWrite), .writeData(outWriteData), .writeOk(outWriteOk),
        .read(outRead), .readData(outReadData), .readOk(outReadOk)
    );

    // Frame is the length byte, then msgLen data bytes
    assign outWrite     = msgActive;
    assign outWriteData = lenSent ? msg : msgLen;
    assign msgTrigger   = msgActive && lenSent && outWriteOk;

    always_ff @(posedge clk) begin
        if (reset) begin
            lenSent <= 1'b0;
        end else if (outWrite && outWriteOk) begin
            if (!lenSent) begin
                lenSent <= 1'b1;
            end else if (msgLen == ByteWidth'(1)) begin
                lenSent <= 1'b0;
            end
        end
    end

    debugSerial serial (
        .debugClk(debugClk), .debugReset(debugReset), .debugCs(debugCs),
        .debugDi(debugDi), .debugDo(debugDo),
        .inWrite(inWrite), .inData(inWriteData), .inWriteOk(inWriteOk),
        .outRead(outRead), .outData(outReadData), .outReadOk(outReadOk)
    );

endmodule

/* logic/debugSerial.sv */
`timescale 1ns/100ps

module debugSerial (
    input  logic                           debugClk,
    input  logic                           debugReset,
    input  logic                           debugCs,
    input  logic                           debugDi,
    output logic                           debugDo,
    output logic                           inWrite,
    output logic [debugPkg::ByteWidth-1:0] inData,
    input  logic                           inWriteOk,
    output logic                           outRead,
    input  logic [debugPkg::ByteWidth-1:0] outData,
    input  logic                           outReadOk
);
    import debugPkg::*;

    logic [ByteWidth-1:0] inShift;
    logic                 inByteDone;

    // Low bit is the end-of-byte sentinel and is never sent
    logic [ByteWidth:0]   outShift;
    logic                 outByteEnd;
    logic                 outReadTaken;

    // ==================================================
    // Host to FIFO
    // ==================================================

    // Commands always have their MSB set, so bit 7 marks a full byte
    assign inByteDone = inShift[ByteWidth-1];
    assign inData     = inShift;

    // A full FIFO drops the byte
    assign inWrite = debugCs && inByteDone && inWriteOk;

    always_ff @(posedge debugClk) begin
        if (debugReset) begin
            inShift <= '0;
        end else if (debugCs) begin
            if (inByteDone) begin
                // Byte handed off, the current bit starts the next one
                inShift <= {{(ByteWidth-1){1'b0}}, debugDi};
            end else begin
                inShift <= {inShift[ByteWidth-2:0], debugDi};
            end
        end
    end

    // ==================================================
    // FIFO to host
    // ==================================================
    assign debugDo = outShift[ByteWidth];

    // Sentinel reached bit 7, so the last data bit is on the wire
    assign outByteEnd = (outShift[ByteWidth-1:0] == {1'b1, {(ByteWidth-1){1'b0}}});

    // Read one bit early, registered FIFO data lands just in time
    assign outRead = debugCs && (outShift[ByteWidth-2:0] == {1'b1, {(ByteWidth-2){1'b0}}});

    always_ff @(posedge debugClk) begin
        if (debugReset) begin
            outShift     <= {{ByteWidth{1'b0}}, 1'b1};
            outReadTaken <= 1'b0;
        end else if (debugCs) begin
            outReadTaken <= outRead && outReadOk;
            if (outByteEnd) begin
                // Empty FIFO sends a zero byte and keeps the byte rhythm
                if (outReadTaken) begin
                    outShift <= {outData, 1'b1};
                end else begin
                    outShift <= {{ByteWidth{1'b0}}, 1'b1};
                end
            end else begin
                outShift <= {outShift[ByteWidth-1:0], 1'b0};
            end
        end
    end

endmodule

/* logic/asyncFifo.sv */
`timescale 1ns/100ps

module asyncFifo #(
    parameter int width = 8,
    parameter int depth = 8
) (
    input  logic             wclk,
    input  logic             rclk,
    input  logic             reset,
    input  logic             write,
    input  logic [width-1:0] writeData,
    output logic             writeOk,
    input  logic             read,
    output logic [width-1:0] readData,
    output logic             readOk
);
    // Pointers carry one extra bit to tell full from empty
    localparam int AddrWidth = $clog2(depth);

    logic [width-1:0] mem [depth];

    logic               wResetMeta;
    logic               wReset;
    logic               writeFire;
    logic [AddrWidth:0] wBin;
    logic [AddrWidth:0] wBinNext;
    logic [AddrWidth:0] wGray;
    logic [AddrWidth:0] rGrayMeta;
    logic [AddrWidth:0] rGraySync;

    logic               rResetMeta;
    logic               rReset;
    logic               readFire;
    logic [AddrWidth:0] rBin;
    logic [AddrWidth:0] rBinNext;
    logic [AddrWidth:0] rGray;
    logic [AddrWidth:0] wGrayMeta;
    logic [AddrWidth:0] wGraySync;

    // ==================================================
    // Write side
    // ==================================================
    always_ff @(posedge wclk) begin
        wResetMeta <= reset;
        wReset     <= wResetMeta;
    end

    assign writeFire = write && writeOk;
    assign wBinNext  = wBin + {{AddrWidth{1'b0}}, writeFire};

    // Full when the read pointer is one lap behind
    assign writeOk = (wGray != {~rGraySync[AddrWidth -: 2], rGraySync[AddrWidth-2:0]});

    always_ff @(posedge wclk) begin
        if (wReset) begin
            wBin      <= '0;
            wGray     <= '0;
            rGrayMeta <= '0;
            rGraySync <= '0;
        end else begin
            wBin      <= wBinNext;
            wGray     <= wBinNext ^ (wBinNext >> 1);
            rGrayMeta <= rGray;
            rGraySync <= rGrayMeta;
        end
    end

    always_ff @(posedge wclk) begin
        if (writeFire) begin
            mem[wBin[AddrWidth-1:0]] <= writeData;
        end
    end

    // ==================================================
    // Read side
    // ==================================================
    always_ff @(posedge rclk) begin
        rResetMeta <= reset;
        rReset     <= rResetMeta;
    end

    assign readFire = read && readOk;
    assign rBinNext = rBin + {{AddrWidth{1'b0}}, readFire};
    assign readOk   = (rGray != wGraySync);

    always_ff @(posedge rclk) begin
        if (rReset) begin
            rBin      <= '0;
            rGray     <= '0;
            wGrayMeta <= '0;
            wGraySync <= '0;
        end else begin
            rBin      <= rBinNext;
            rGray     <= rBinNext ^ (rBinNext >> 1);
            wGrayMeta <= wGray;
            wGraySync <= wGrayMeta;
        end
    end

    // Data shows up the cycle after the read is taken
    always_ff @(posedge rclk) begin
        if (readFire) begin
            readData <= mem[rBin[AddrWidth-1:0]];
        end
    end

endmodule

/* logic/debugPkg.sv */
package debugPkg;

    // ==================================================
    // Data path sizes
    // ==================================================

    // One command or message byte
    localparam int ByteWidth = 8;

    // Commands arrive one at a time, so a short queue is enough
    localparam int InFifoDepth = 8;

    // Responses may pile up while the host is not clocking
    localparam int OutFifoDepth = 512;

    localparam int LedCount = 4;

    // ==================================================
    // Command codes
    // ==================================================

    // Idle byte, never queued by the serial framer
    localparam logic [ByteWidth-1:0] CmdNop = 8'h00;

    localparam logic [ByteWidth-1:0] CmdLedOff = 8'h80;
    localparam logic [ByteWidth-1:0] CmdLedOn  = 8'h81;

    // Answers with the LED value and the executed-command count
    localparam logic [ByteWidth-1:0] CmdStatus = 8'h82;

    // High nibble of CmdLedSet, low nibble carries the LED pattern
    localparam logic [ByteWidth-1:0] CmdLedSetMask = 8'hA0;

endpackage
